// ==== design/msix_pkg.sv ====
// shared MSI-X types and address map constants; AXI-lite data fixed at 32 bits, index width up to 6
`ifndef MSIX_PKG_SV
`define MSIX_PKG_SV

package msix_pkg;

    localparam int axil_data_w = 32;
    localparam int tlp_hdr_w = 128;

    // address map: region bit sits at index width + pba_sel_off
    localparam int pba_sel_off = 4;
    localparam int tbl_word_lsb = 3;   // entry index and half-entry select start here
    localparam int dword_sel_bit = 2;  // picks the 32-bit half

    typedef struct packed {
        logic [7:0] bus_num;
        logic [7:0] func_num;
        logic       enable;
        logic       mask;
    } msix_cfg_t;

    typedef struct packed {
        logic [63:0] addr;  // low two bits always zero
        logic [31:0] data;
        logic        masked;
    } msix_vec_t;

    typedef struct packed {
        logic [tlp_hdr_w-1:0] hdr;
        logic [31:0]          data;
    } tlp_req_t;

    typedef enum logic [2:0] {
        fmt_3dw      = 3'b000,
        fmt_4dw      = 3'b001,
        fmt_3dw_data = 3'b010,
        fmt_4dw_data = 3'b011,
        fmt_prefix   = 3'b100
    } tlp_fmt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read_tbl_1,
        st_read_tbl_2,
        st_send_tlp
    } irq_state_t;

endpackage

`endif

// ==== design/msix_table.sv ====
// vector table RAM, 64-bit words zeroed at start only; AXI-lite port reads win over writes in one cycle
module msix_table #(
    parameter int irq_index_w = 6
) (
    input  logic                 clk,

    input  logic                 axil_wr_en,
    input  logic [7:0]           axil_wr_be,
    input  logic [irq_index_w:0] axil_addr,
    input  logic [63:0]          axil_wr_data,
    input  logic                 axil_rd_en,
    output logic [63:0]          axil_rd_data,

    input  logic                 eng_rd_en,
    input  logic [irq_index_w:0] eng_addr,
    output logic [63:0]          eng_rd_data
);

    localparam int depth = 2 ** (irq_index_w + 1);

    logic [63:0] mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // AXI-lite side, byte writes
    always @(posedge clk) begin
        if (axil_rd_en) begin
            axil_rd_data <= mem[axil_addr];
        end else if (axil_wr_en) begin
            for (int i = 0; i < 8; i++) begin
                if (axil_wr_be[i]) begin
                    mem[axil_addr][8*i +: 8] <= axil_wr_data[8*i +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (eng_rd_en) begin
            eng_rd_data <= mem[eng_addr]; // engine side, read only
        end
    end

endmodule

// ==== design/msix_axil_regs.sv ====
// AXI-lite slave for table and PBA; responses always OKAY, PBA writes are ignored, one access per cycle
module msix_axil_regs #(
    parameter int irq_index_w = 6
) (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [irq_index_w+4:0]               awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [msix_pkg::axil_data_w-1:0]     wdata,
    input  logic [msix_pkg::axil_data_w/8-1:0]   wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic                                 bvalid,
    input  logic                                 bready,

    input  logic [irq_index_w+4:0]               araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [msix_pkg::axil_data_w-1:0]     rdata,
    output logic                                 rvalid,
    input  logic                                 rready,

    output logic                                 tbl_wr_en,
    output logic [7:0]                           tbl_wr_be,
    output logic [irq_index_w:0]                 tbl_addr,
    output logic [63:0]                          tbl_wr_data,
    output logic                                 tbl_rd_en,
    input  logic [63:0]                          tbl_rd_data,

    input  logic [63:0]                          pba
);

    import msix_pkg::*;

    localparam int region_bit = irq_index_w + pba_sel_off;

    logic write_eligible;
    logic read_eligible;
    logic take_wr;
    logic take_rd;
    logic rd_drain;
    logic last_read;
    logic tbl_pend;     // table data waiting for the R channel
    logic pba_pend;
    logic rd_half;
    logic [63:0] pba_snap;
    logic [63:0] rd_word;

    assign write_eligible = awvalid && wvalid && (!bvalid || bready) && !awready;
    assign read_eligible = arvalid && !arready
                           && (!rvalid || rready || !(tbl_pend || pba_pend));

    // alternate when both sides want the port
    assign take_wr = write_eligible && (!read_eligible || last_read);
    assign take_rd = read_eligible && !take_wr;

    assign rd_drain = (tbl_pend || pba_pend) && (!rvalid || rready);

    assign tbl_wr_en = take_wr && !awaddr[region_bit];
    assign tbl_wr_be = awaddr[dword_sel_bit] ? {wstrb, 4'b0000} : {4'b0000, wstrb};
    assign tbl_wr_data = {2{wdata}};
    assign tbl_rd_en = take_rd && !araddr[region_bit];
    assign tbl_addr = take_wr ? awaddr[tbl_word_lsb +: irq_index_w+1]
                              : araddr[tbl_word_lsb +: irq_index_w+1];

    assign rd_word = tbl_pend ? tbl_rd_data : pba_snap;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            tbl_pend <= 1'b0;
            pba_pend <= 1'b0;
            last_read <= 1'b0;
        end else begin
            awready <= take_wr;
            wready <= take_wr;
            if (take_wr) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            arready <= take_rd;
            if (rd_drain) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            tbl_pend <= take_rd ? !araddr[region_bit] : (tbl_pend && !rd_drain);
            pba_pend <= take_rd ? araddr[region_bit] : (pba_pend && !rd_drain);

            if (take_wr) begin
                last_read <= 1'b0;
            end else if (take_rd) begin
                last_read <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_rd) begin
            rd_half <= araddr[dword_sel_bit];
            if (araddr[region_bit]) begin
                pba_snap <= pba;
            end
        end
        if (rd_drain) begin
            rdata <= rd_half ? rd_word[63:32] : rd_word[31:0];
        end
    end

endmodule

// ==== design/msix_irq_engine.sv ====
// request and pending-scan FSM owning the 64-bit PBA; irq_ready stays low while a TLP is outstanding
module msix_irq_engine #(
    parameter int irq_index_w = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  msix_pkg::msix_cfg_t    cfg,

    input  logic [irq_index_w-1:0] irq_index,
    input  logic                   irq_valid,
    output logic                   irq_ready,

    output logic                   tbl_rd_en,
    output logic [irq_index_w:0]   tbl_addr,
    input  logic [63:0]            tbl_rd_data,

    input  logic                   busy,
    output logic                   send,
    output msix_pkg::msix_vec_t    vec,

    output logic [63:0]            pba
);

    import msix_pkg::*;

    irq_state_t state;
    irq_state_t state_next;
    logic [irq_index_w-1:0] index;
    logic [irq_index_w-1:0] index_next;
    msix_vec_t vec_next;
    logic [63:0] pba_next;
    logic irq_ready_next;
    logic fn_active;

    assign fn_active = cfg.enable && !cfg.mask;

    always_comb begin
        state_next = state;
        index_next = index;
        vec_next = vec;
        pba_next = pba;
        tbl_rd_en = 1'b0;
        tbl_addr = {index, 1'b0};
        send = 1'b0;

        case (state)
            st_idle: begin
                if (irq_valid && irq_ready) begin
                    index_next = irq_index;
                    tbl_rd_en = 1'b1;
                    tbl_addr = {irq_index, 1'b0};
                    state_next = st_read_tbl_1;
                end else if (!irq_valid && fn_active && pba != '0) begin
                    if (pba[index]) begin
                        tbl_rd_en = 1'b1; // retry this pending vector
                        state_next = st_read_tbl_1;
                    end else begin
                        index_next = index + 1'b1;
                    end
                end
            end
            st_read_tbl_1: begin
                tbl_rd_en = 1'b1;
                tbl_addr = {index, 1'b1};
                vec_next.addr = {tbl_rd_data[63:2], 2'b00};
                state_next = st_read_tbl_2;
            end
            st_read_tbl_2: begin
                vec_next.data = tbl_rd_data[31:0];
                vec_next.masked = tbl_rd_data[32];
                if (fn_active && !vec_next.masked) begin
                    state_next = st_send_tlp;
                end else begin
                    pba_next[index] = 1'b1;
                    // step on so the scan does not spin on a still masked vector
                    index_next = index + 1'b1;
                    state_next = st_idle;
                end
            end
            st_send_tlp: begin
                if (!busy) begin
                    send = 1'b1;
                    pba_next[index] = 1'b0;
                    index_next = index + 1'b1;
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase

        // tlp_valid next cycle is send or busy
        irq_ready_next = (state_next == st_idle) && !send && !busy;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            index <= '0;
            pba <= '0;
            irq_ready <= 1'b0;
        end else begin
            state <= state_next;
            index <= index_next;
            pba <= pba_next;
            irq_ready <= irq_ready_next;
        end
    end

    always_ff @(posedge clk) begin
        vec <= vec_next;
    end

endmodule

// ==== design/msix_tlp_out.sv ====
// single-dword memory-write TLP register; send must only come while busy is low
module msix_tlp_out (
    input  logic                 clk,
    input  logic                 rst,
    input  msix_pkg::msix_cfg_t  cfg,
    input  logic                 send,
    input  msix_pkg::msix_vec_t  vec,
    output logic                 busy,
    output msix_pkg::tlp_req_t   tlp,
    output logic                 tlp_valid,
    input  logic                 tlp_ready
);

    import msix_pkg::*;

    logic [tlp_hdr_w-1:0] hdr;
    logic addr_64;
    tlp_fmt_t fmt;

    assign addr_64 = vec.addr[63:32] != '0;
    assign fmt = addr_64 ? fmt_4dw_data : fmt_3dw_data;

    always_comb begin
        hdr = '0;
        hdr[127:125] = fmt;
        hdr[124:120] = 5'b00000;                   // memory write
        hdr[105:96] = 10'd1;                       // one dword
        hdr[95:80] = {cfg.bus_num, cfg.func_num};  // requester ID
        hdr[79:72] = 8'd0;                         // tag
        hdr[71:68] = 4'b0000;
        hdr[67:64] = 4'b1111;
        if (addr_64) begin
            hdr[63:2] = vec.addr[63:2];
        end else begin
            hdr[63:34] = vec.addr[31:2]; // dword 3 stays zero
        end
    end

    assign busy = tlp_valid && !tlp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tlp_valid <= 1'b0;
        end else begin
            tlp_valid <= send || busy;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            tlp.hdr <= hdr;
            tlp.data <= vec.data;
        end
    end

endmodule

// ==== design/msix_top.sv ====
// MSI-X controller top; cfg takes effect one cycle late, irq_index_w from 1 to 6
module msix_top #(
    parameter int irq_index_w = 6
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic [irq_index_w+4:0]             awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [msix_pkg::axil_data_w-1:0]   wdata,
    input  logic [msix_pkg::axil_data_w/8-1:0] wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [irq_index_w+4:0]             araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [msix_pkg::axil_data_w-1:0]   rdata,
    output logic                               rvalid,
    input  logic                               rready,

    input  msix_pkg::msix_cfg_t                cfg,

    input  logic [irq_index_w-1:0]             irq_index,
    input  logic                               irq_valid,
    output logic                               irq_ready,

    output msix_pkg::tlp_req_t                 tlp,
    output logic                               tlp_valid,
    input  logic                               tlp_ready
);

    import msix_pkg::*;

    msix_cfg_t cfg_reg;

    logic tbl_wr_en;
    logic [7:0] tbl_wr_be;
    logic [irq_index_w:0] tbl_axil_addr;
    logic [63:0] tbl_wr_data;
    logic tbl_axil_rd_en;
    logic [63:0] tbl_axil_rd_data;

    logic eng_rd_en;
    logic [irq_index_w:0] eng_addr;
    logic [63:0] eng_rd_data;

    logic [63:0] pba;
    logic busy;
    logic send;
    msix_vec_t vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_reg <= '0;
        end else begin
            cfg_reg <= cfg;
        end
    end

    msix_axil_regs #(.irq_index_w(irq_index_w)) u_regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .tbl_wr_en, .tbl_wr_be, .tbl_addr(tbl_axil_addr), .tbl_wr_data,
        .tbl_rd_en(tbl_axil_rd_en), .tbl_rd_data(tbl_axil_rd_data),
        .pba
    );

    msix_table #(.irq_index_w(irq_index_w)) u_table (
        .clk,
        .axil_wr_en(tbl_wr_en), .axil_wr_be(tbl_wr_be), .axil_addr(tbl_axil_addr),
        .axil_wr_data(tbl_wr_data), .axil_rd_en(tbl_axil_rd_en),
        .axil_rd_data(tbl_axil_rd_data),
        .eng_rd_en, .eng_addr, .eng_rd_data
    );

    msix_irq_engine #(.irq_index_w(irq_index_w)) u_engine (
        .clk, .rst, .cfg(cfg_reg),
        .irq_index, .irq_valid, .irq_ready,
        .tbl_rd_en(eng_rd_en), .tbl_addr(eng_addr), .tbl_rd_data(eng_rd_data),
        .busy, .send, .vec, .pba
    );

    msix_tlp_out u_tlp_out (
        .clk, .rst, .cfg(cfg_reg),
        .send, .vec, .busy,
        .tlp, .tlp_valid, .tlp_ready
    );

endmodule

// ==== sim/msix_sva.sv ====
// handshake assertions bound onto msix_top; all properties are off while rst is high
module msix_sva (
    input logic                clk,
    input logic                rst,
    input logic                awready,
    input logic                wready,
    input logic                rvalid,
    input logic                rready,
    input logic                irq_ready,
    input msix_pkg::tlp_req_t  tlp,
    input logic                tlp_valid,
    input logic                tlp_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    aw_w_together: assert property (@(posedge clk) disable iff (rst) awready == wready)
        else $error("awready and wready differ");

    tlp_held: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp))
        else $error("tlp changed or dropped under back-pressure");

    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // no new request while a TLP waits
    irq_blocked: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |-> !irq_ready)
        else $error("irq_ready high while tlp waits");

endmodule

bind msix_top msix_sva sva0 (
    .clk(clk), .rst(rst), .awready(awready), .wready(wready),
    .rvalid(rvalid), .rready(rready), .irq_ready(irq_ready),
    .tlp(tlp), .tlp_valid(tlp_valid), .tlp_ready(tlp_ready)
);

// ==== sim/msix_tb.sv ====
// testbench for msix_top with irq_index_w 6; bready stays high, rready stalls on reads, stops at the first error
module msix_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import msix_pkg::*;

    localparam int idx_w = 6;
    localparam int pba_base = 1 << (idx_w + 4);
    localparam int max_cycles = 20000; // table sweep is about 2000 cycles, the rest far less

    logic clk;
    logic rst;
    logic [idx_w+4:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic [idx_w+4:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic rvalid;
    logic rready;
    msix_cfg_t cfg;
    logic [idx_w-1:0] irq_index;
    logic irq_valid;
    logic irq_ready;
    tlp_req_t tlp;
    logic tlp_valid;
    logic tlp_ready;

    logic [31:0] tbl_model [256];  // one dword per table word half
    tlp_req_t exp_q [$];
    tlp_req_t tlp_held;
    int tlp_count = 0;
    int b_count = 0;
    int r_count = 0;
    int cycle_count = 0;
    int match_idx;
    int bp_left = 0;
    logic bp_on = 1'b0;
    logic tlp_wait = 1'b0;
    logic rd_wait = 1'b0;

    msix_top #(.irq_index_w(idx_w)) dut0 (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [159:0] got, input logic [159:0] exp);
        if (got !== exp) begin
            $display("ERR time %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [idx_w+4:0] dword_addr(input int dw);
        logic [31:0] byte_addr;
        byte_addr = dw * 4;
        return byte_addr[idx_w+4:0];
    endfunction

    function automatic logic [63:0] random_addr(input bit wide);
        logic [31:0] hi;
        hi = wide ? ($urandom | 32'h1) : 32'h0;
        return {hi, $urandom};
    endfunction

    // expected memory-write TLP from the table model and cfg
    function automatic tlp_req_t ref_tlp(input int idx);
        logic [63:0] addr;
        logic [31:0] dw0;
        logic [31:0] dw1;
        logic [31:0] dw2;
        logic [31:0] dw3;
        tlp_req_t t;
        addr = {tbl_model[idx*4+1], tbl_model[idx*4] & 32'hffff_fffc};
        dw1 = {cfg.bus_num, cfg.func_num, 8'h00, 4'h0, 4'hf};
        if (addr[63:32] != 32'h0) begin
            dw0 = {fmt_4dw_data, 5'b00000, 14'd0, 10'd1};
            dw2 = addr[63:32];
            dw3 = addr[31:0];
        end else begin
            dw0 = {fmt_3dw_data, 5'b00000, 14'd0, 10'd1};
            dw2 = addr[31:0];
            dw3 = 32'h0;
        end
        t.hdr = {dw0, dw1, dw2, dw3};
        t.data = tbl_model[idx*4+2];
        return t;
    endfunction

    task automatic axil_write(input logic [idx_w+4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do @(posedge clk); while (!bvalid); // bvalid rises with awready
        awvalid <= 1'b0;
        wvalid <= 1'b0;
    endtask

    task automatic axil_read(input logic [idx_w+4:0] addr, output logic [31:0] data);
        int stall;
        stall = $urandom_range(0, 3);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        rready <= (stall == 0);
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk); // response held off a few cycles
        rready <= 1'b1;
        do @(posedge clk); while (!(rvalid && rready));
        data = rdata;
    endtask

    task automatic table_write(input int dw, input logic [31:0] data, input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                tbl_model[dw][8*b +: 8] = data[8*b +: 8];
            end
        end
        axil_write(dword_addr(dw), data, strb);
    endtask

    task automatic set_entry(input int idx, input logic [63:0] addr, input logic [31:0] data,
                             input logic [31:0] ctrl);
        table_write(idx*4, addr[31:0], 4'hf);
        table_write(idx*4+1, addr[63:32], 4'hf);
        table_write(idx*4+2, data, 4'hf);
        table_write(idx*4+3, ctrl, 4'hf);
    endtask

    task automatic read_pba(output logic [63:0] value);
        logic [31:0] lo;
        logic [31:0] hi;
        axil_read(dword_addr(pba_base / 4), lo);
        axil_read(dword_addr(pba_base / 4 + 1), hi);
        value = {hi, lo};
    endtask

    task automatic raise_irq(input logic [idx_w-1:0] idx);
        @(posedge clk);
        irq_index <= idx;
        irq_valid <= 1'b1;
        do @(posedge clk); while (!irq_ready);
        irq_valid <= 0;
    endtask

    task automatic wait_tlps(input int n);
        while (tlp_count < n) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            abort_run("timeout, the test sequence did not finish");
        end
    end

    // random back-pressure stretches
    always @(posedge clk) begin
        if (!bp_on) begin
            tlp_ready <= 1'b1;
        end else if (bp_left == 0) begin
            tlp_ready <= $urandom_range(0, 1);
            bp_left <= $urandom_range(1, 8);
        end else begin
            bp_left <= bp_left - 1;
        end
    end

    // compare every TLP handshake, any order among the queued ones
    always @(posedge clk) begin
        if (!rst && tlp_valid && tlp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("TLP sent with no request outstanding");
            end else begin
                match_idx = -1;
                foreach (exp_q[i]) begin
                    if (match_idx < 0 && exp_q[i] == tlp) match_idx = i;
                end
                if (match_idx < 0) begin
                    check("tlp", tlp, exp_q[0]);
                end else begin
                    exp_q.delete(match_idx);
                    tlp_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            check("wready", wready, awready);
            if (tlp_valid && !tlp_ready) check("irq_ready", irq_ready, 1'b0);
            if (tlp_wait) begin
                check("tlp_valid", tlp_valid, 1'b1);
                check("tlp", tlp, tlp_held);
            end
            if (rd_wait) check("rvalid", rvalid, 1'b1);
            if (bvalid && bready) b_count++;
            if (rvalid && rready) r_count++;
        end
        tlp_wait = !rst && tlp_valid && !tlp_ready;
        tlp_held = tlp;
        rd_wait = !rst && rvalid && !rready;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [63:0] pba_rd;
        logic [63:0] pend;
        int sent;
        int idx;

        void'($urandom(32'h8720));
        clk = 1'b0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        cfg.bus_num = $urandom;
        cfg.func_num = $urandom;
        cfg.enable = 1'b1;
        cfg.mask = 1'b0;
        irq_index = '0;
        irq_valid = 1'b0;
        tlp_ready = 1'b1;
        sent = 0;
        foreach (tbl_model[i]) tbl_model[i] = 32'h0;

        repeat (2) @(posedge clk);
        check("reset outputs", {awready, wready, bvalid, arready, rvalid, irq_ready, tlp_valid},
              7'd0);
        check("engine state", dut0.u_engine.state, st_idle);
        rst <= 1'b0;

        // table access with random strobes
        for (int i = 0; i < 128; i++) begin
            r = $urandom;
            table_write($urandom_range(0, 255), $urandom, r[3:0]);
        end
        for (int i = 0; i < 256; i++) begin
            axil_read(dword_addr(i), rd);
            check("rdata", rd, tbl_model[i]);
        end
        repeat (2) @(posedge clk);
        check("bvalid count", b_count, 128);
        check("rvalid count", r_count, 256);

        // delivery, odd vectors get 64-bit addresses
        for (int i = 0; i < 8; i++) begin
            set_entry(i, random_addr(i % 2 == 1), $urandom, 32'h0);
        end
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back(ref_tlp(i));
            raise_irq(i);
            sent++;
            wait_tlps(sent);
            read_pba(pba_rd);
            check("pba bit", pba_rd[i], 1'b0);
        end

        // masked vector held pending until unmasked
        set_entry(10, random_addr(1'b1), $urandom, 32'h1);
        raise_irq(10);
        repeat (50) @(posedge clk);
        check("tlp count", tlp_count, sent);
        read_pba(pba_rd);
        check("pba bit", pba_rd[10], 1'b1);
        exp_q.push_back(ref_tlp(10));
        sent++;
        table_write(10*4+3, 32'h0, 4'hf);
        wait_tlps(sent);
        read_pba(pba_rd);
        check("pba bit", pba_rd[10], 1'b0);

        // function masked, then disabled
        @(posedge clk);
        cfg.mask <= 1'b1;
        repeat (2) @(posedge clk);
        pend = '0;
        for (int i = 20; i < 28; i++) begin
            set_entry(i, random_addr(i > 23), $urandom, 32'h0);
            raise_irq(i);
            pend[i] = 1'b1;
        end
        @(posedge clk);
        cfg.mask <= 1'b0;
        cfg.enable <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 30; i < 34; i++) begin
            set_entry(i, random_addr(i % 2 == 0), $urandom, 32'h0);
            raise_irq(i);
            pend[i] = 1'b1;
        end
        repeat (50) @(posedge clk);
        check("tlp count", tlp_count, sent);
        read_pba(pba_rd);
        check("pba", pba_rd, pend);
        for (int i = 0; i < 64; i++) begin
            if (pend[i]) begin
                exp_q.push_back(ref_tlp(i));
                sent++;
            end
        end
        @(posedge clk);
        cfg.enable <= 1'b1;
        wait_tlps(sent);
        repeat (10) @(posedge clk);
        read_pba(pba_rd);
        check("pba", pba_rd, 64'h0);

        // back-pressure on the TLP output
        @(posedge clk);
        bp_on <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            idx = $urandom_range(0, 7);
            exp_q.push_back(ref_tlp(idx));
            raise_irq(idx);
            sent++;
        end
        wait_tlps(sent);
        @(posedge clk);
        bp_on <= 1'b0;

        repeat (10) @(posedge clk);
        if (exp_q.size() == 0 && tlp_count == sent) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("expected TLPs left over at the end of the run");
        end
    end

endmodule

// ==== msix_ctrl.f ====
design/msix_pkg.sv
design/msix_table.sv
design/msix_axil_regs.sv
design/msix_irq_engine.sv
design/msix_tlp_out.sv
design/msix_top.sv
sim/msix_sva.sv
sim/msix_tb.sv
